// ==== include/alu_defines.svh ====
// sequential alu widths, booth step count and op code size
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// operand and result word width, signed
`define ALU_WIDTH 8

// radix-4 booth retires two multiplier bits per step
`define ALU_RADIX4_STEPS (`ALU_WIDTH / 2)

// 00 add, 01 sub, 10 mul; 11 is not a legal code
`define ALU_OP_WIDTH 2

`endif

// ==== source/alu_pkg.sv ====
// alu package with the word, accumulator, op code and FSM state types
`default_nettype none
`include "alu_defines.svh"

package alu_pkg;

    typedef logic [`ALU_WIDTH-1:0] word_t;  // one bus word / operand

    // A register, two guard bits so that +-2M can never overflow it
    typedef logic [`ALU_WIDTH+1:0] acc_t;

    typedef logic [$clog2(`ALU_RADIX4_STEPS)-1:0] step_t;  // radix-4 step counter

    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        op_add = 2'b00,
        op_sub = 2'b01,
        op_mul = 2'b10  // code 11 left unassigned and rejected by control
    } op_t;

    // one-hot encoding, one flop per state
    typedef enum logic [8:0] {
        st_idle          = 9'b0_0000_0001,
        st_load_first    = 9'b0_0000_0010,  // A (add/sub) or Q (mul) from inbus
        st_load_m        = 9'b0_0000_0100,
        st_add           = 9'b0_0000_1000,  // A <= A +- M or A +- 2M
        st_rshift        = 9'b0_0001_0000,
        st_rshift_double = 9'b0_0010_0000,  // second shift of the step
        st_count         = 9'b0_0100_0000,
        st_push_a        = 9'b0_1000_0000,
        st_push_q        = 9'b1_0000_0000
    } state_t;

endpackage

`default_nettype wire

// ==== source/alu_ctrl_if.sv ====
// control unit to datapath link, strobes one way and Q status bits back
`default_nettype none

interface alu_ctrl_if;

    logic       load_a;     // A <= inbus, sign extended
    logic       load_q;     // Q <= inbus
    logic       load_m;     // M <= inbus, sign extended
    logic       init_mul;   // clear A and Q[-1] alongside load_q
    logic       add_en;     // A <= adder result
    logic       select_2m;  // addend is 2M instead of M
    logic       subtract;   // adder subtracts
    logic       rshift;     // one bit arithmetic shift of A:Q:Q[-1]
    logic       push_a;     // outbus <= low word of A
    logic       push_q;     // outbus <= Q
    logic [2:0] q_bits;     // {Q[1], Q[0], Q[-1]} for booth recoding

    modport ctrl (
        output load_a, load_q, load_m, init_mul,
        output add_en, select_2m, subtract, rshift,
        output push_a, push_q,
        input  q_bits
    );

    modport dp (
        input  load_a, load_q, load_m, init_mul,
        input  add_en, select_2m, subtract, rshift,
        input  push_a, push_q,
        output q_bits
    );

endinterface

`default_nettype wire

// ==== source/alu_control.sv ====
// alu control unit, one-hot FSM that sequences add/sub and radix-4 booth multiply
`default_nettype none
`include "alu_defines.svh"

module alu_control (
    input  wire logic         clk,
    input  wire logic         arst_n,
    input  wire logic         begin_op,
    input  wire alu_pkg::op_t op_code,
    output logic              busy,
    output logic              done,
    alu_ctrl_if.ctrl          ctrl
);

    alu_pkg::state_t state;      // current state
    alu_pkg::state_t state_nxt;  // strobes are decoded from this one
    alu_pkg::op_t    op_lat;     // op code held for the whole operation
    alu_pkg::step_t  step_cnt;   // radix-4 steps already finished

    logic op_legal;   // 11 is rejected at begin
    logic is_mul;
    logic booth_add;  // recoded digit is nonzero
    logic last_step;

    assign op_legal = (op_code == alu_pkg::op_add) || (op_code == alu_pkg::op_sub)
                   || (op_code == alu_pkg::op_mul);
    assign is_mul    = (op_lat == alu_pkg::op_mul);
    assign booth_add = (|ctrl.q_bits) & ~(&ctrl.q_bits);  // 000 and 111 skip the add
    assign last_step = (step_cnt == alu_pkg::step_t'(`ALU_RADIX4_STEPS - 1));

    // state register, idle flop comes out of reset set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= alu_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            alu_pkg::st_idle: begin
                if (begin_op && op_legal) begin  // begin with code 11 stays here
                    state_nxt = alu_pkg::st_load_first;
                end
            end
            alu_pkg::st_load_first: state_nxt = alu_pkg::st_load_m;
            alu_pkg::st_load_m: begin
                if (!is_mul || booth_add) begin
                    state_nxt = alu_pkg::st_add;
                end else begin
                    state_nxt = alu_pkg::st_rshift;  // first digit is zero
                end
            end
            alu_pkg::st_add: begin
                state_nxt = is_mul ? alu_pkg::st_rshift : alu_pkg::st_push_a;
            end
            alu_pkg::st_rshift: state_nxt = alu_pkg::st_rshift_double;
            alu_pkg::st_rshift_double: begin
                state_nxt = last_step ? alu_pkg::st_push_a : alu_pkg::st_count;
            end
            alu_pkg::st_count: begin
                state_nxt = booth_add ? alu_pkg::st_add : alu_pkg::st_rshift;
            end
            alu_pkg::st_push_a: begin
                state_nxt = is_mul ? alu_pkg::st_push_q : alu_pkg::st_idle;
            end
            alu_pkg::st_push_q: state_nxt = alu_pkg::st_idle;
            default:            state_nxt = alu_pkg::st_idle;  // lost one-hot, recover
        endcase
    end

    // op code latched on the sampling edge, running ops ignore begin_op
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_lat <= alu_pkg::op_add;
        end else if (state_nxt == alu_pkg::st_load_first) begin
            op_lat <= op_code;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            step_cnt <= '0;
        end else if (state_nxt == alu_pkg::st_load_m) begin
            step_cnt <= '0;  // fresh count per multiply
        end else if (state_nxt == alu_pkg::st_count) begin
            step_cnt <= step_cnt + alu_pkg::step_t'(1);
        end
    end

    // load strobes, only reached from idle so op_code is still the live input
    assign ctrl.load_a   = (state_nxt == alu_pkg::st_load_first) && (op_code != alu_pkg::op_mul);
    assign ctrl.load_q   = (state_nxt == alu_pkg::st_load_first) && (op_code == alu_pkg::op_mul);
    assign ctrl.init_mul = ctrl.load_q;
    assign ctrl.load_m   = (state_nxt == alu_pkg::st_load_m);

    // adder control
    assign ctrl.add_en    = (state_nxt == alu_pkg::st_add);
    assign ctrl.select_2m = ctrl.add_en && is_mul
                         && ((ctrl.q_bits == 3'b011) || (ctrl.q_bits == 3'b100));  // +-2M digits
    assign ctrl.subtract  = ctrl.add_en
                         && (is_mul ? ctrl.q_bits[2] : (op_lat == alu_pkg::op_sub));

    assign ctrl.rshift = (state_nxt == alu_pkg::st_rshift)
                      || (state_nxt == alu_pkg::st_rshift_double);

    assign ctrl.push_a = (state_nxt == alu_pkg::st_push_a);
    assign ctrl.push_q = (state_nxt == alu_pkg::st_push_q);

    // done lines up with out_valid of the last word
    assign done = ((state == alu_pkg::st_push_a) && !is_mul) || (state == alu_pkg::st_push_q);
    assign busy = (state != alu_pkg::st_idle);

endmodule

`default_nettype wire

// ==== source/alu_datapath.sv ====
// alu datapath, A/Q/Q[-1]/M registers with booth adder, shifter and output register
`default_nettype none
`include "alu_defines.svh"

module alu_datapath (
    input  wire logic           clk,
    input  wire logic           arst_n,
    input  wire alu_pkg::word_t inbus,
    output alu_pkg::word_t      outbus,
    output logic                out_valid,
    alu_ctrl_if.dp              dp
);

    localparam int acc_w = $bits(alu_pkg::acc_t);
    localparam int ext_w = acc_w - `ALU_WIDTH;  // guard bits above a word

    alu_pkg::acc_t  a_reg;    // accumulator, high product word ends up in its low bits
    alu_pkg::word_t q_reg;    // multiplier, low product word at the end
    logic           q_m1;     // Q[-1]
    alu_pkg::acc_t  m_reg;    // sign extended second operand

    alu_pkg::acc_t  in_ext;   // inbus widened to accumulator size
    alu_pkg::acc_t  addend;   // M or 2M
    alu_pkg::acc_t  add_b;    // addend, inverted when subtracting
    alu_pkg::acc_t  sum;

    assign in_ext = {{ext_w{inbus[`ALU_WIDTH-1]}}, inbus};

    assign addend = dp.select_2m ? {m_reg[acc_w-2:0], 1'b0} : m_reg;
    assign add_b  = addend ^ {acc_w{dp.subtract}};
    assign sum    = a_reg + add_b + alu_pkg::acc_t'(dp.subtract);  // two's complement sub

    assign dp.q_bits = {q_reg[1:0], q_m1};

    // A register
    always_ff @(posedge clk) begin
        if (dp.load_a) begin
            a_reg <= in_ext;
        end else if (dp.init_mul) begin
            a_reg <= '0;
        end else if (dp.add_en) begin
            a_reg <= sum;
        end else if (dp.rshift) begin
            a_reg <= {a_reg[acc_w-1], a_reg[acc_w-1:1]};  // keep sign
        end
    end

    // Q and Q[-1] shift along under A
    always_ff @(posedge clk) begin
        if (dp.load_q) begin
            q_reg <= inbus;
        end else if (dp.rshift) begin
            q_reg <= {a_reg[0], q_reg[`ALU_WIDTH-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (dp.init_mul) begin
            q_m1 <= 1'b0;
        end else if (dp.rshift) begin
            q_m1 <= q_reg[0];
        end
    end

    always_ff @(posedge clk) begin
        if (dp.load_m) begin
            m_reg <= in_ext;
        end
    end

    // output register, one cycle strobe per pushed word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            outbus    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= dp.push_a | dp.push_q;
            if (dp.push_a) begin
                outbus <= a_reg[`ALU_WIDTH-1:0];  // sum, or product high word
            end else if (dp.push_q) begin
                outbus <= q_reg;  // product low word
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/seq_alu.sv ====
// sequential signed alu top, control unit and datapath behind plain ports
`default_nettype none
`include "alu_defines.svh"

module seq_alu (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    input  wire logic                     begin_op,   // one cycle start pulse
    input  wire logic [`ALU_OP_WIDTH-1:0] op_code,
    input  wire alu_pkg::word_t           inbus,      // x with begin_op, y next cycle
    output alu_pkg::word_t                outbus,
    output logic                          out_valid,
    output logic                          done,       // with the last word
    output logic                          busy
);

    // raw code into the enum type, 11 passes through and is rejected by control
    alu_pkg::op_t op_code_e;

    assign op_code_e = alu_pkg::op_t'(op_code);

    alu_ctrl_if ctrl_bus ();

    alu_control i_alu_control (
        .clk      (clk),
        .arst_n   (arst_n),
        .begin_op (begin_op),
        .op_code  (op_code_e),
        .busy     (busy),
        .done     (done),
        .ctrl     (ctrl_bus.ctrl)
    );

    alu_datapath i_alu_datapath (
        .clk       (clk),
        .arst_n    (arst_n),
        .inbus     (inbus),
        .outbus    (outbus),
        .out_valid (out_valid),
        .dp        (ctrl_bus.dp)
    );

endmodule

`default_nettype wire

// ==== verif/seq_alu_checker.sv ====
// seq_alu checker, predicts the output words of each operation and compares them with outbus
`default_nettype none
`include "alu_defines.svh"

module seq_alu_checker (
    input wire logic                     clk,
    input wire logic                     arst_n,
    input wire logic                     begin_op,
    input wire logic [`ALU_OP_WIDTH-1:0] op_code,
    input wire alu_pkg::word_t           inbus,
    input wire alu_pkg::word_t           outbus,
    input wire logic                     out_valid,
    input wire logic                     done,
    input wire logic                     busy
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int w = `ALU_WIDTH;
    localparam int addsub_latency = 4;  // sampling edge to the edge that sees done

    int                       error_count = 0;
    int                       check_count = 0;
    alu_pkg::word_t           exp_q [$];        // expected words in push order
    alu_pkg::word_t           exp_word;
    logic [2*w-1:0]           result;
    logic [`ALU_OP_WIDTH-1:0] op_cur;
    alu_pkg::word_t           x_cur;            // first operand, y comes one cycle later
    string                    cur_name = "idle";
    logic                     capture_y = 1'b0;
    logic                     in_op = 1'b0;     // mirrors the expected busy
    logic                     want_next = 1'b0; // second product word due this cycle
    int                       op_index = 0;
    int                       lat_cnt = 0;

    // expected result from the op rules, mul gives {high, low}, add/sub only the low word
    function automatic logic [2*w-1:0] ref_result(input logic [`ALU_OP_WIDTH-1:0] op,
                                                   input alu_pkg::word_t x,
                                                   input alu_pkg::word_t y);
        logic signed [2*w-1:0] xs;
        logic signed [2*w-1:0] ys;
        alu_pkg::word_t        low;
        xs  = {{w{x[w-1]}}, x};  // signed operands
        ys  = {{w{y[w-1]}}, y};
        low = (op == alu_pkg::op_sub) ? x - y : x + y;  // wraps to 8 bits
        if (op == alu_pkg::op_mul) begin
            return xs * ys;
        end
        return {{w{1'b0}}, low};
    endfunction

    function automatic string op_name(input logic [`ALU_OP_WIDTH-1:0] op);
        case (op)
            alu_pkg::op_add: return "add";
            alu_pkg::op_sub: return "sub";
            default:         return "mul";
        endcase
    endfunction

    task automatic report_mismatch(input string what, input logic [w-1:0] exp_v,
                                   input logic [w-1:0] act_v);
        error_count++;
        $display("FAIL %s %s expected %h actual %h at %0t", cur_name, what, exp_v, act_v, $time);
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR %s at %0t", msg, $time);
    endtask

    // sampled on the rising edge, so inputs and outputs are the values of the cycle just ended
    always @(posedge clk) begin
        if (!arst_n) begin
            if (out_valid !== 1'b0 || done !== 1'b0 || busy !== 1'b0) begin
                report_problem("outputs are not low during reset");
            end
            exp_q.delete();
            in_op     = 1'b0;
            capture_y = 1'b0;
            want_next = 1'b0;
        end else begin
            if (in_op) lat_cnt++;
            if (busy !== in_op) report_mismatch("busy", w'(in_op), w'(busy));
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    report_problem("out_valid with no word expected");
                end else begin
                    check_count++;
                    exp_word = exp_q.pop_front();
                    if (outbus !== exp_word) report_mismatch("word", exp_word, outbus);
                    if (done !== (exp_q.size() == 0)) begin
                        report_mismatch("done", w'(exp_q.size() == 0), w'(done));
                    end
                    if (exp_q.size() == 0 && op_cur != alu_pkg::op_mul
                        && lat_cnt != addsub_latency) begin
                        report_problem($sformatf("%s took %0d cycles instead of %0d",
                                                 cur_name, lat_cnt, addsub_latency));
                    end
                end
                want_next = (exp_q.size() != 0);  // mul low word must follow at once
            end else begin
                if (want_next) report_problem("product low word did not follow the high word");
                want_next = 1'b0;
                if (done === 1'b1) report_problem("done without an output word");
            end
            if (done === 1'b1) in_op = 1'b0;
            if (capture_y) begin  // y is on inbus the cycle after begin
                result = ref_result(op_cur, x_cur, inbus);
                if (op_cur == alu_pkg::op_mul) exp_q.push_back(result[2*w-1:w]);
                exp_q.push_back(result[w-1:0]);
                capture_y = 1'b0;
            end
            // code 11 and begin while running start nothing
            if (begin_op === 1'b1 && !in_op && op_code != 2'b11) begin
                op_cur    = op_code;
                x_cur     = inbus;
                capture_y = 1'b1;
                in_op     = 1'b1;
                lat_cnt   = 0;
                op_index++;
                cur_name  = $sformatf("%s #%0d", op_name(op_code), op_index);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/seq_alu_tb.sv ====
// seq_alu testbench, random and corner stimulus for add, sub and booth multiply
`default_nettype none
`include "alu_defines.svh"

module seq_alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period  = 40;
    localparam int n_add       = 40;
    localparam int n_sub       = 40;
    localparam int n_mul       = 60;
    localparam int n_corner    = 7;   // every pair of corner operands is multiplied
    localparam int n_ops       = n_add + n_sub + n_mul + n_corner * n_corner + 3;
    localparam int done_limit  = 30;  // cycles allowed per operation
    localparam int watchdog_ns = n_ops * 30 * clk_period + 2000;

    logic                     clk;
    logic                     arst_n;
    logic                     begin_op;
    logic [`ALU_OP_WIDTH-1:0] op_code;
    alu_pkg::word_t           inbus;
    alu_pkg::word_t           outbus;
    logic                     out_valid;
    logic                     done;
    logic                     busy;
    int                       tb_errors = 0;

    // -128, -1, 0, 1, 127 and the two alternating bit patterns
    alu_pkg::word_t corner [n_corner] = '{8'h80, 8'hff, 8'h00, 8'h01, 8'h7f, 8'h55, 8'haa};

    always #(clk_period / 2) clk = ~clk;

    seq_alu i_seq_alu (
        .clk(clk), .arst_n(arst_n), .begin_op(begin_op), .op_code(op_code), .inbus(inbus),
        .outbus(outbus), .out_valid(out_valid), .done(done), .busy(busy)
    );

    seq_alu_checker i_seq_alu_checker (
        .clk(clk), .arst_n(arst_n), .begin_op(begin_op), .op_code(op_code), .inbus(inbus),
        .outbus(outbus), .out_valid(out_valid), .done(done), .busy(busy)
    );

    function automatic alu_pkg::word_t rand_word();
        return alu_pkg::word_t'($urandom);
    endfunction

    // x with begin, y next cycle, then wait for done; stray pulses begin while busy
    task automatic run_op(input logic [`ALU_OP_WIDTH-1:0] op, input alu_pkg::word_t x,
                          input alu_pkg::word_t y, input bit stray);
        int cycles;
        @(negedge clk);
        begin_op = 1'b1;
        op_code  = op;
        inbus    = x;
        @(negedge clk);
        begin_op = 1'b0;
        inbus    = y;
        cycles   = 0;
        while (done !== 1'b1 && cycles < done_limit) begin
            @(negedge clk);
            cycles++;
            inbus    = rand_word();  // junk, must not reach the result
            begin_op = stray && (cycles == 2);
        end
        begin_op = 1'b0;
        if (done !== 1'b1) begin
            tb_errors++;
            $display("ERROR no done within %0d cycles of operation code %0d", done_limit, op);
        end
    endtask

    // code 11 must leave the DUT idle, the checker watches busy/out_valid/done
    task automatic run_illegal(input alu_pkg::word_t x, input alu_pkg::word_t y);
        @(negedge clk);
        begin_op = 1'b1;
        op_code  = 2'b11;
        inbus    = x;
        @(negedge clk);
        begin_op = 1'b0;
        inbus    = y;
        repeat (done_limit) @(negedge clk);
    endtask

    initial begin
        int total;
        clk      = 1'b0;
        arst_n   = 1'b1;
        begin_op = 1'b0;
        op_code  = '0;
        inbus    = '0;
        void'($urandom(32'h8d54));  // one seed for the whole run
        #1;
        arst_n = 1'b0;  // falling edge starts the asynchronous reset
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        repeat (4) @(negedge clk);  // quiet outputs expected before the first begin
        for (int i = 0; i < n_add; i++) run_op(alu_pkg::op_add, rand_word(), rand_word(), 1'b1);
        for (int i = 0; i < n_sub; i++) run_op(alu_pkg::op_sub, rand_word(), rand_word(), 1'b1);
        run_illegal(rand_word(), rand_word());
        for (int i = 0; i < n_mul; i++) run_op(alu_pkg::op_mul, rand_word(), rand_word(), 1'b1);
        for (int i = 0; i < n_corner; i++) begin
            for (int j = 0; j < n_corner; j++) begin
                run_op(alu_pkg::op_mul, corner[i], corner[j], 1'b0);  // skip, +-M, +-2M digits
            end
        end
        run_illegal(rand_word(), rand_word());
        run_op(alu_pkg::op_add, 8'h7f, 8'h01, 1'b0);  // legal op right after an illegal one
        repeat (4) @(negedge clk);
        if (i_seq_alu_checker.in_op) begin
            tb_errors++;
            $display("ERROR an operation was still open at the end of the run");
        end
        total = tb_errors + i_seq_alu_checker.error_count;
        $display("words checked %0d, checker errors %0d, bench errors %0d",
                 i_seq_alu_checker.check_count, i_seq_alu_checker.error_count, tb_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // bound on the whole run, 30 cycles per operation plus margin
    initial begin
        #(watchdog_ns);
        $display("ERROR watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== seq_alu.f ====
+incdir+include
source/alu_pkg.sv
source/alu_ctrl_if.sv
source/alu_control.sv
source/alu_datapath.sv
source/seq_alu.sv
verif/seq_alu_checker.sv
verif/seq_alu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module seq_alu_tb -f seq_alu.f -o seq_alu_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/seq_alu_sim | tee /dev/stderr | grep -x "ALL CHECKS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
